/* src/spi_pkg.sv */
`default_nettype none

package spi_pkg;

    localparam int NCS = 4;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [1:0]  cs_t;
    typedef logic [7:0]  len_t;   // bytes minus one
    typedef logic [3:0]  pm_t;
    typedef logic [3:0]  dly_t;

    localparam int TXF_DEPTH = 4;    // words
    localparam int RXF_DEPTH = 16;   // bytes
    localparam int RXCNT_W   = $clog2(RXF_DEPTH + 1);

    localparam addr_t ADDR_SPMODE  = 8'h00;
    localparam addr_t ADDR_SPIE    = 8'h04;
    localparam addr_t ADDR_SPIM    = 8'h08;
    localparam addr_t ADDR_SPCOM   = 8'h0C;
    localparam addr_t ADDR_SPITF   = 8'h10;
    localparam addr_t ADDR_SPIRF   = 8'h14;
    localparam addr_t ADDR_CSMODE0 = 8'h20;   // selects 1..3 at 0x24, 0x28, 0x2c

    localparam int SPMODE_EN = 31;

    localparam int SPIE_DON      = 31;
    localparam int SPIE_RNE      = 30;
    localparam int SPIE_TNF      = 29;
    localparam int SPIE_TXE      = 28;
    localparam int SPIE_RXCNT_HI = 4;
    localparam int SPIE_RXCNT_LO = 0;

    localparam int SPCOM_CS_HI  = 31;
    localparam int SPCOM_CS_LO  = 30;
    localparam int SPCOM_LEN_HI = 7;
    localparam int SPCOM_LEN_LO = 0;

    localparam int CSMODE_CPOL   = 31;
    localparam int CSMODE_CPHA   = 30;
    localparam int CSMODE_POL    = 29;   // 1 = select active high
    localparam int CSMODE_PM_HI  = 27;
    localparam int CSMODE_PM_LO  = 24;
    localparam int CSMODE_BEF_HI = 15;
    localparam int CSMODE_BEF_LO = 12;
    localparam int CSMODE_AFT_HI = 11;
    localparam int CSMODE_AFT_LO = 8;

    // mode 0, active-low select, fastest clock
    localparam word_t CSMODE_DEF = 32'h0000_0000;

endpackage

`default_nettype wire

/* src/spi_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         S_SYSCLK,
    input  logic                         S_RESETN,
    input  logic                         i_push,
    input  payload_t                     i_data,
    input  logic                         i_pop,
    output payload_t                     o_data,
    output logic                         o_empty,
    output logic                         o_full,
    output logic [$clog2(DEPTH+1)-1:0]   o_count
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

payload_t        mem [DEPTH];
logic [AW-1:0]   wr_ptr;
logic [AW-1:0]   rd_ptr;
logic            do_push;
logic            do_pop;

assign do_push = i_push && !o_full;    // dropped when full
assign do_pop  = i_pop && !o_empty;
assign o_empty = (o_count == '0);
assign o_full  = (o_count == CW'(DEPTH));
assign o_data  = mem[rd_ptr];          // head word, valid while not empty

always_ff @(posedge S_SYSCLK) begin
    if (do_push) begin
        mem[wr_ptr] <= i_data;
    end
end

always_ff @(posedge S_SYSCLK) begin
    if (!S_RESETN) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        o_count <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({do_push, do_pop})
            2'b10:   o_count <= o_count + 1'b1;
            2'b01:   o_count <= o_count - 1'b1;
            default: ;
        endcase
    end
end

endmodule

`default_nettype wire

/* src/spi_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_clk_gen import spi_pkg::*; (
    input  logic S_SYSCLK,
    input  logic S_RESETN,
    input  logic i_run,
    input  pm_t  i_pm,
    output logic o_edge
);

pm_t cnt;

// one o_edge pulse per sck half period, every pm+1 clocks
always_ff @(posedge S_SYSCLK) begin
    if (!S_RESETN) begin
        cnt    <= '0;
        o_edge <= 1'b0;
    end else if (!i_run) begin
        cnt    <= i_pm;   // restart so the first half period is whole
        o_edge <= 1'b0;
    end else if (cnt == '0) begin
        cnt    <= i_pm;
        o_edge <= 1'b1;
    end else begin
        cnt    <= cnt - 1'b1;
        o_edge <= 1'b0;
    end
end

endmodule

`default_nettype wire

/* src/spi_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_regs import spi_pkg::*; (
    input  logic               S_SYSCLK,
    input  logic               S_RESETN,
    input  addr_t              i_awaddr,
    input  word_t              i_wdata,
    input  logic [3:0]         i_wstrb,
    input  logic               i_wen,
    input  addr_t              i_araddr,
    input  logic               i_rden,
    output word_t              o_rdata,
    output logic               o_interrupt,
    input  logic               i_tx_full,
    input  logic               i_tx_empty,
    input  logic               i_rx_empty,
    input  logic [RXCNT_W-1:0] i_rx_count,
    input  byte_t              i_rx_data,
    output logic               o_tx_push,
    output word_t              o_tx_data,
    output logic               o_rx_pop,
    input  logic               i_frame_done,
    output logic               o_frame_start,
    output logic               o_cpol,
    output logic               o_cpha,
    output logic [NCS-1:0]     o_sel_pol,
    output pm_t                o_pm,
    output dly_t               o_bef,
    output dly_t               o_aft,
    output cs_t                o_cs,
    output len_t               o_len
);

word_t spmode;
word_t spim;
word_t spcom;
logic  don;
word_t csmode [NCS];
word_t spie;
word_t cur_mode;
logic  en;
logic  wr_ok;
logic  wr_csmode;
logic  rd_csmode;

assign en        = spmode[SPMODE_EN];
assign wr_ok     = i_wen && (i_wstrb == 4'hF);   // full-word writes only
assign wr_csmode = wr_ok && (i_awaddr[7:4] == ADDR_CSMODE0[7:4]) && (i_awaddr[1:0] == 2'b00);
assign rd_csmode = (i_araddr[7:4] == ADDR_CSMODE0[7:4]) && (i_araddr[1:0] == 2'b00);

always_ff @(posedge S_SYSCLK) begin
    if (!S_RESETN) begin
        spmode        <= '0;
        spim          <= '0;
        spcom         <= '0;
        don           <= 1'b0;
        o_frame_start <= 1'b0;
        for (int i = 0; i < NCS; i++) begin
            csmode[i] <= CSMODE_DEF;
        end
    end else begin
        o_frame_start <= 1'b0;
        if (wr_ok) begin
            case (i_awaddr)
                ADDR_SPMODE: spmode <= i_wdata;
                ADDR_SPIM:   spim   <= i_wdata;
                ADDR_SPCOM: begin
                    spcom         <= i_wdata;
                    o_frame_start <= en;   // fields settle before the start pulse
                end
                default: ;
            endcase
        end
        if (wr_csmode) begin
            csmode[i_awaddr[3:2]] <= i_wdata;
        end
        // a frame end in the same cycle as a clear wins
        if (i_frame_done) begin
            don <= 1'b1;
        end else if (wr_ok && (i_awaddr == ADDR_SPIE) && i_wdata[SPIE_DON]) begin
            don <= 1'b0;
        end
    end
end

always_comb begin
    spie                              = '0;
    spie[SPIE_DON]                    = don;
    spie[SPIE_RNE]                    = !i_rx_empty;
    spie[SPIE_TNF]                    = i_tx_full;   // set while tx fifo full
    spie[SPIE_TXE]                    = i_tx_empty;
    spie[SPIE_RXCNT_HI:SPIE_RXCNT_LO] = i_rx_count;
end

assign o_interrupt = |(spim & spie);

assign o_tx_push = wr_ok && (i_awaddr == ADDR_SPITF) && en && !i_tx_full;
assign o_tx_data = i_wdata;
assign o_rx_pop  = i_rden && (i_araddr == ADDR_SPIRF) && !i_rx_empty;

// mode of the select named in spcom
assign cur_mode = csmode[spcom[SPCOM_CS_HI:SPCOM_CS_LO]];
assign o_cpol   = cur_mode[CSMODE_CPOL];
assign o_cpha   = cur_mode[CSMODE_CPHA];
assign o_pm     = cur_mode[CSMODE_PM_HI:CSMODE_PM_LO];
assign o_bef    = cur_mode[CSMODE_BEF_HI:CSMODE_BEF_LO];
assign o_aft    = cur_mode[CSMODE_AFT_HI:CSMODE_AFT_LO];
assign o_cs     = spcom[SPCOM_CS_HI:SPCOM_CS_LO];
assign o_len    = spcom[SPCOM_LEN_HI:SPCOM_LEN_LO];

always_comb begin
    for (int i = 0; i < NCS; i++) begin
        o_sel_pol[i] = csmode[i][CSMODE_POL];
    end
end

always_comb begin
    o_rdata = '0;
    case (i_araddr)
        ADDR_SPMODE: o_rdata = spmode;
        ADDR_SPIE:   o_rdata = spie;
        ADDR_SPIM:   o_rdata = spim;
        ADDR_SPCOM:  o_rdata = spcom;
        ADDR_SPIRF: begin
            if (!i_rx_empty) begin
                o_rdata = word_t'(i_rx_data);
            end
        end
        default: begin
            if (rd_csmode) begin
                o_rdata = csmode[i_araddr[3:2]];
            end
        end
    endcase
end

endmodule

`default_nettype wire

/* src/spi_frame_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_frame_ctrl import spi_pkg::*; (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  logic           i_frame_start,
    input  logic           i_cpol,
    input  logic           i_cpha,
    input  logic [NCS-1:0] i_sel_pol,
    input  dly_t           i_bef,
    input  dly_t           i_aft,
    input  cs_t            i_cs,
    input  len_t           i_len,
    input  logic           i_edge,
    input  word_t          i_tx_data,
    input  logic           i_tx_empty,
    input  logic           i_spi_miso,
    output logic           o_run,
    output logic           o_tx_pop,
    output logic           o_rx_push,
    output byte_t          o_rx_data,
    output logic           o_frame_done,
    output logic           o_spi_sck,
    output logic           o_spi_mosi,
    output logic [NCS-1:0] o_spi_sel
);

typedef enum logic [2:0] {ST_IDLE, ST_BEF, ST_WAIT, ST_XFER, ST_AFT} state_t;

state_t     state;
cs_t        cs_q;
logic       cpha_q;
len_t       bytes_left;
logic [1:0] byte_idx;    // byte of the head word now on the wire
logic [1:0] ld_idx;
logic [3:0] hp;          // half period within the byte
dly_t       dly_cnt;
dly_t       aft_q;
logic       sck_q;
logic       mosi_q;
logic       done_q;
logic       push_q;
byte_t      tx_sr;
byte_t      rx_sr;
byte_t      ld_byte;
logic       xfer_edge;
logic       sample_edge;
logic       shift_edge;
logic       byte_end;
logic       word_end;
logic       load;

assign xfer_edge   = i_edge && (state == ST_XFER);
assign sample_edge = xfer_edge && (cpha_q ? hp[0] : !hp[0]);
assign shift_edge  = xfer_edge && (cpha_q ? !hp[0] : (hp[0] && hp != 4'hF));
assign byte_end    = xfer_edge && (hp == 4'hF);
assign word_end    = byte_end && ((bytes_left == '0) || (byte_idx == 2'd3));
assign load        = ((state == ST_WAIT) && !i_tx_empty) || (byte_end && !word_end);
assign ld_idx      = (state == ST_WAIT) ? byte_idx : byte_idx + 2'd1;
assign ld_byte     = i_tx_data[{ld_idx, 3'b000} +: 8];   // lsb byte goes first

// clock generator restarts in ST_WAIT
assign o_run        = (state == ST_BEF) || (state == ST_XFER) || (state == ST_AFT);
assign o_tx_pop     = word_end;
assign o_rx_push    = push_q;
assign o_rx_data    = rx_sr;
assign o_frame_done = done_q;
assign o_spi_sck    = (state == ST_IDLE) ? i_cpol : sck_q;
assign o_spi_mosi   = mosi_q;

always_comb begin
    for (int i = 0; i < NCS; i++) begin
        o_spi_sel[i] = ((state != ST_IDLE) && (cs_q == cs_t'(i))) ~^ i_sel_pol[i];
    end
end

always_ff @(posedge S_SYSCLK) begin
    if (load) begin
        tx_sr <= cpha_q ? ld_byte : {ld_byte[6:0], 1'b0};
    end else if (shift_edge) begin
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
    if (sample_edge) begin
        rx_sr <= {rx_sr[6:0], i_spi_miso};   // msb first
    end
end

always_ff @(posedge S_SYSCLK) begin
    if (!S_RESETN) begin
        state      <= ST_IDLE;
        cs_q       <= '0;
        cpha_q     <= 1'b0;
        bytes_left <= '0;
        byte_idx   <= '0;
        hp         <= '0;
        dly_cnt    <= '0;
        aft_q      <= '0;
        sck_q      <= 1'b0;
        mosi_q     <= 1'b0;
        done_q     <= 1'b0;
        push_q     <= 1'b0;
    end else begin
        done_q <= 1'b0;
        push_q <= sample_edge && (hp[3:1] == 3'b111);   // last sample of the byte
        if (load && !cpha_q) begin
            mosi_q <= ld_byte[7];   // first bit ahead of the leading edge
        end else if (shift_edge) begin
            mosi_q <= tx_sr[7];
        end
        case (state)
            ST_IDLE: begin
                if (i_frame_start) begin
                    state      <= ST_BEF;
                    cs_q       <= i_cs;
                    cpha_q     <= i_cpha;
                    sck_q      <= i_cpol;
                    bytes_left <= i_len;
                    dly_cnt    <= i_bef;
                    aft_q      <= i_aft;
                    byte_idx   <= '0;
                    hp         <= '0;
                end
            end
            ST_BEF: begin
                if (dly_cnt == '0) begin
                    state <= ST_WAIT;
                end else if (i_edge) begin
                    dly_cnt <= dly_cnt - 1'b1;
                end
            end
            ST_WAIT: begin
                if (!i_tx_empty) begin
                    state <= ST_XFER;
                end
            end
            ST_XFER: begin
                if (i_edge) begin
                    sck_q <= !sck_q;
                    hp    <= hp + 1'b1;
                end
                if (byte_end) begin
                    byte_idx <= byte_idx + 1'b1;
                    if (bytes_left == '0) begin
                        state   <= ST_AFT;
                        dly_cnt <= aft_q;
                    end else begin
                        bytes_left <= bytes_left - 1'b1;
                        if (byte_idx == 2'd3) begin
                            state <= ST_WAIT;   // next word shows after the pop
                        end
                    end
                end
            end
            ST_AFT: begin
                if (dly_cnt == '0) begin
                    state  <= ST_IDLE;
                    done_q <= 1'b1;
                end else if (i_edge) begin
                    dly_cnt <= dly_cnt - 1'b1;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

endmodule

`default_nettype wire

/* src/spi_master_top.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_master_top import spi_pkg::*; (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  addr_t          i_awaddr,
    input  word_t          i_wdata,
    input  logic [3:0]     i_wstrb,
    input  logic           i_wen,
    input  addr_t          i_araddr,
    input  logic           i_rden,
    output word_t          o_rdata,
    output logic           o_interrupt,
    output logic           o_spi_sck,
    input  logic           i_spi_miso,
    output logic           o_spi_mosi,
    output logic [NCS-1:0] o_spi_sel
);

logic               tx_push, tx_pop, tx_full, tx_empty;
word_t              tx_wdata, tx_rdata;
logic               rx_push, rx_pop, rx_empty;
byte_t              rx_wdata, rx_rdata;
logic [RXCNT_W-1:0] rx_count;
logic               frame_start, frame_done, run, sck_edge;
logic               cpol, cpha;
logic [NCS-1:0]     sel_pol;
pm_t                pm;
dly_t               bef, aft;
cs_t                cs;
len_t               len;

spi_regs spi_regs_i (
    .S_SYSCLK, .S_RESETN, .i_awaddr, .i_wdata, .i_wstrb, .i_wen, .i_araddr, .i_rden,
    .o_rdata, .o_interrupt,
    .i_tx_full(tx_full), .i_tx_empty(tx_empty), .i_rx_empty(rx_empty),
    .i_rx_count(rx_count), .i_rx_data(rx_rdata),
    .o_tx_push(tx_push), .o_tx_data(tx_wdata), .o_rx_pop(rx_pop),
    .i_frame_done(frame_done), .o_frame_start(frame_start),
    .o_cpol(cpol), .o_cpha(cpha), .o_sel_pol(sel_pol), .o_pm(pm),
    .o_bef(bef), .o_aft(aft), .o_cs(cs), .o_len(len)
);

spi_fifo #(.payload_t(word_t), .DEPTH(TXF_DEPTH)) tx_fifo (
    .S_SYSCLK, .S_RESETN,
    .i_push(tx_push), .i_data(tx_wdata), .i_pop(tx_pop),
    .o_data(tx_rdata), .o_empty(tx_empty), .o_full(tx_full), .o_count()
);

spi_fifo #(.payload_t(byte_t), .DEPTH(RXF_DEPTH)) rx_fifo (
    .S_SYSCLK, .S_RESETN,
    .i_push(rx_push), .i_data(rx_wdata), .i_pop(rx_pop),
    .o_data(rx_rdata), .o_empty(rx_empty), .o_full(), .o_count(rx_count)
);

spi_clk_gen spi_clk_gen_i (
    .S_SYSCLK, .S_RESETN, .i_run(run), .i_pm(pm), .o_edge(sck_edge)
);

spi_frame_ctrl spi_frame_ctrl_i (
    .S_SYSCLK, .S_RESETN, .i_frame_start(frame_start),
    .i_cpol(cpol), .i_cpha(cpha), .i_sel_pol(sel_pol), .i_bef(bef), .i_aft(aft),
    .i_cs(cs), .i_len(len), .i_edge(sck_edge),
    .i_tx_data(tx_rdata), .i_tx_empty(tx_empty), .i_spi_miso,
    .o_run(run), .o_tx_pop(tx_pop), .o_rx_push(rx_push), .o_rx_data(rx_wdata),
    .o_frame_done(frame_done), .o_spi_sck, .o_spi_mosi, .o_spi_sel
);

endmodule

`default_nettype wire

/* testbench/tb_spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spi_master import spi_pkg::*; ();

localparam int DONE_POLLS = 2000;   // SPIE reads before giving up

logic           S_SYSCLK;
logic           S_RESETN;
addr_t          i_awaddr;
word_t          i_wdata;
logic [3:0]     i_wstrb;
logic           i_wen;
addr_t          i_araddr;
logic           i_rden;
word_t          o_rdata;
logic           o_interrupt;
logic           o_spi_sck;
logic           i_spi_miso = 1'b0;
logic           o_spi_mosi;
logic [NCS-1:0] o_spi_sel;

// register values as written, used to follow the slave's mode
word_t csmode_tb [NCS];
word_t spcom_tb;
byte_t reply_q[$];
byte_t mosi_exp_q[$];
byte_t mosi_got_q[$];

logic  sel_prev = 1'b0;
logic  sck_prev = 1'b0;
int    bitcnt;
int    bytes_loaded;
byte_t miso_sr;
byte_t mosi_sr;

spi_master_top spi_master_top_i (
    .S_SYSCLK, .S_RESETN, .i_awaddr, .i_wdata, .i_wstrb, .i_wen, .i_araddr, .i_rden,
    .o_rdata, .o_interrupt, .o_spi_sck, .i_spi_miso, .o_spi_mosi, .o_spi_sel
);

initial begin
    S_SYSCLK = 1'b0;
    forever #5 S_SYSCLK = ~S_SYSCLK;
end

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
        report_failure($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        report_failure($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_bits(input string what, input logic [NCS-1:0] got,
                          input logic [NCS-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

function automatic logic mode_bit(input int pos);
    return csmode_tb[spcom_tb[SPCOM_CS_HI:SPCOM_CS_LO]][pos];
endfunction

function automatic logic [NCS-1:0] idle_sel();
    logic [NCS-1:0] v;
    for (int i = 0; i < NCS; i++) begin
        v[i] = !csmode_tb[i][CSMODE_POL];   // inactive level
    end
    return v;
endfunction

task automatic write_reg(input addr_t a, input word_t d);
    @(negedge S_SYSCLK);
    i_awaddr = a;
    i_wdata  = d;
    i_wstrb  = 4'hF;
    i_wen    = 1'b1;
    @(posedge S_SYSCLK);
    if (a == ADDR_SPCOM) begin
        spcom_tb = d;
    end
    if ((a[7:4] == ADDR_CSMODE0[7:4]) && (a[1:0] == 2'b00)) begin
        csmode_tb[a[3:2]] = d;
    end
    @(negedge S_SYSCLK);
    i_wen = 1'b0;
endtask

task automatic read_reg(input addr_t a, input logic pop, output word_t d);
    @(negedge S_SYSCLK);
    i_araddr = a;
    @(negedge S_SYSCLK);
    d      = o_rdata;   // pop lands on the next rising edge
    i_rden = pop;
    @(negedge S_SYSCLK);
    i_rden = 1'b0;
endtask

task automatic load_reply();
    if ((bytes_loaded < int'(spcom_tb[SPCOM_LEN_HI:SPCOM_LEN_LO]) + 1)
            && (reply_q.size() > 0)) begin
        miso_sr = reply_q.pop_front();
    end else begin
        miso_sr = 8'h00;
    end
    bytes_loaded++;
    i_spi_miso = miso_sr[7];
    miso_sr    = miso_sr << 1;
endtask

// frame end, then the bytes the slave saw on MOSI
task automatic wait_done();
    word_t s;
    int    n;
    s = '0;
    n = 0;
    while (!s[SPIE_DON]) begin
        if (n == DONE_POLLS) begin
            report_failure("timeout: DON never set in SPIE after the frame was started");
        end
        read_reg(ADDR_SPIE, 1'b0, s);
        n++;
    end
    check_word("MOSI byte count", word_t'(mosi_got_q.size()), word_t'(mosi_exp_q.size()));
    while (mosi_exp_q.size() > 0) begin
        check_byte("MOSI byte", mosi_got_q.pop_front(), mosi_exp_q.pop_front());
    end
endtask

task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge S_SYSCLK);
        check_bits("selects with EN clear", o_spi_sel, idle_sel());
    end
endtask

// slave model and select / sck monitor, all on the falling edge
always @(negedge S_SYSCLK) begin
    cs_t            cs;
    logic           act;
    logic [NCS-1:0] exp_sel;
    cs  = spcom_tb[SPCOM_CS_HI:SPCOM_CS_LO];
    act = S_RESETN && (o_spi_sel[cs] == mode_bit(CSMODE_POL));
    if (S_RESETN) begin
        exp_sel     = idle_sel();
        exp_sel[cs] = o_spi_sel[cs];   // only the addressed select may move
        check_bits("unaddressed selects", o_spi_sel, exp_sel);
        if (!act) begin
            check_bits("idle sck", NCS'(o_spi_sck), NCS'(mode_bit(CSMODE_CPOL)));
        end
    end
    if (act && !sel_prev) begin
        bitcnt       = 0;
        bytes_loaded = 0;
        if (!mode_bit(CSMODE_CPHA)) begin
            load_reply();   // first bit ahead of the leading edge
        end
    end else if (act && (o_spi_sck != sck_prev)) begin
        if ((o_spi_sck != mode_bit(CSMODE_CPOL)) != mode_bit(CSMODE_CPHA)) begin
            mosi_sr = {mosi_sr[6:0], o_spi_mosi};
            bitcnt++;
            if (bitcnt == 8) begin
                mosi_got_q.push_back(mosi_sr);
            end
        end else if ((bitcnt == 8) || (mode_bit(CSMODE_CPHA) && (bitcnt == 0))) begin
            bitcnt = 0;
            load_reply();
        end else begin
            i_spi_miso = miso_sr[7];
            miso_sr    = miso_sr << 1;
        end
    end
    sel_prev = act;
    sck_prev = o_spi_sck;
end

initial begin
    int    fd;
    int    code;
    byte   c;
    addr_t a;
    word_t d;
    word_t rd;
    i_awaddr = '0;
    i_wdata  = '0;
    i_wstrb  = '0;
    i_wen    = 1'b0;
    i_araddr = '0;
    i_rden   = 1'b0;
    spcom_tb = '0;
    for (int i = 0; i < NCS; i++) begin
        csmode_tb[i] = CSMODE_DEF;
    end
    S_RESETN = 1'b0;
    repeat (3) @(posedge S_SYSCLK);
    @(negedge S_SYSCLK);
    S_RESETN = 1'b1;

    fd = $fopen("testbench/spi_stimulus.txt", "r");
    if (fd == 0) begin
        report_failure("cannot open testbench/spi_stimulus.txt");
    end
    while (!$feof(fd)) begin
        code = $fscanf(fd, "%c", c);
        if (code != 1) begin
            break;
        end
        case (c)
            "#": begin
                do begin
                    code = $fscanf(fd, "%c", c);
                end while ((code == 1) && (c != "\n"));
            end
            "W": begin
                code = $fscanf(fd, "%h %h", a, d);
                write_reg(a, d);
            end
            "R": begin
                code = $fscanf(fd, "%h %h", a, d);
                read_reg(a, 1'b0, rd);
                check_word($sformatf("register %h", a), rd, d);
            end
            "B": begin
                code = $fscanf(fd, "%h", d);
                read_reg(ADDR_SPIRF, 1'b1, rd);
                check_byte("SPIRF byte", rd[7:0], d[7:0]);
            end
            "S": begin
                code = $fscanf(fd, "%h", d);
                reply_q.push_back(d[7:0]);
            end
            "M": begin
                code = $fscanf(fd, "%h", d);
                mosi_exp_q.push_back(d[7:0]);
            end
            "L": begin
                code = $fscanf(fd, "%h %h", a, d);
                @(negedge S_SYSCLK);
                check_bits("selects", o_spi_sel, a[NCS-1:0]);
                check_bits("interrupt", NCS'(o_interrupt), NCS'(d[0]));
            end
            "Q": begin
                code = $fscanf(fd, "%h", d);
                check_quiet(int'(d));
            end
            "D": wait_done();
            " ", "\n", "\r", "\t": ;
            default: report_failure("unknown command in the stimulus file");
        endcase
    end
    $fclose(fd);
    $display("** PASS **");
    $finish;
end

endmodule

`default_nettype wire

/* testbench/spi_stimulus.txt */
# cmd args in hex: W addr data, R addr expect, B expected SPIRF byte, S slave reply, M MOSI byte
# D waits for DON and checks MOSI, L selects irq checks levels, Q cycles with selects idle
L 0F 0 R 00 00000000 R 04 10000000 R 20 00000000
# mode 0 on select 0, DON unmasked
W 00 80000000 W 08 80000000 W 20 00000000
S A5 S 3C S 0F S F0 M 44 M 33 M 22 M 11
W 10 11223344 W 0C 00000003 D
L 0F 1 R 04 D0000004 B A5 R 04 D0000003 B 3C B 0F B F0 R 04 90000000
W 04 80000000 L 0F 0 R 04 10000000
# mode 1 on select 2, select active high, prescaler 1, delays, DON masked
W 08 00000000 W 28 61002100 L 0B 0 R 28 61002100
S A5 S 3C S 0F S F0 M 44 M 33 M 22 M 11
W 10 11223344 W 0C 80000003 D
L 0B 0 R 04 D0000004 W 08 80000000 L 0B 1
B A5 B 3C B 0F B F0 W 04 80000000 L 0B 0
# mode 2 on select 2
W 28 A0000000 S A5 S 3C S 0F S F0 M 44 M 33 M 22 M 11
W 10 11223344 W 0C 80000003 D
L 0B 1 B A5 B 3C B 0F B F0 W 04 80000000 L 0B 0 R 04 10000000
# mode 3 on select 2
W 28 E0000000 S A5 S 3C S 0F S F0 M 44 M 33 M 22 M 11
W 10 11223344 W 0C 80000003 D
L 0B 1 B A5 B 3C B 0F B F0 W 04 80000000 L 0B 0 R 04 10000000
# SPCOM with EN clear starts nothing
W 00 00000000 W 0C 00000003 Q 28 L 0B 0 R 04 10000000 R 00 00000000

/* tb.f */
src/spi_pkg.sv
src/spi_fifo.sv
src/spi_clk_gen.sv
src/spi_regs.sv
src/spi_frame_ctrl.sv
src/spi_master_top.sv
testbench/tb_spi_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
